// ==== Bender.yml ====
package:
  name: smartnic_app

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/app_pkt_pkg.sv
      - hdl/app_mem_pkg.sv
      - hdl/stream_fifo.sv
      - hdl/flow_table_ram.sv
      - hdl/mem_arbiter.sv
      - hdl/flow_lookup.sv
      - hdl/mgmt_regs.sv
      - hdl/smartnic_app.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_smartnic_app.sv

// ==== hdl/app_mem_pkg.sv ====
`include "smartnic_app_params.svh"

package app_mem_pkg;

    // ========================================
    // Flow table types
    // ========================================

    // Drop flag lands in bit 2, port in bits 1:0
    typedef struct packed {
        logic                drop;
        app_pkt_pkg::port_t  egress;
    } flow_entry_t;

    // One table access as seen by the arbiter
    typedef struct packed {
        logic                      wr;
        logic [`FLOW_KEY_BITS-1:0] idx;
        flow_entry_t               wr_entry;
    } mem_req_t;

    // ========================================
    // Management port types
    // ========================================

    typedef struct packed {
        logic        wr;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } mgmt_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } mgmt_rsp_t;

endpackage

// ==== hdl/app_pkt_pkg.sv ====
`include "smartnic_app_params.svh"

package app_pkt_pkg;

    // ========================================
    // Packet stream types
    // ========================================

    // Ingress or egress port number
    typedef logic [1:0] port_t;

    // One AXI-Stream beat, tdest travels separately
    typedef struct packed {
        logic [`APP_DATA_BYTES*8-1:0] tdata;
        logic [`APP_DATA_BYTES-1:0]   tkeep;
        logic                         tlast;
        port_t                        tid;
    } axis_beat_t;

    // Outcome of one table lookup
    typedef struct packed {
        port_t egress;
        logic  drop;
    } fwd_decision_t;

endpackage

// ==== hdl/flow_lookup.sv ====
`timescale 1ns/1ps
`include "smartnic_app_params.svh"

module flow_lookup (
    input  logic                      axil_if,
    input  logic                      arst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  app_pkt_pkg::axis_beat_t   in_beat,
    output logic                      out_valid,
    input  logic                      out_ready,
    output app_pkt_pkg::axis_beat_t   out_beat,
    output app_pkt_pkg::port_t        out_tdest,
    output logic                      req_valid,
    output app_mem_pkg::mem_req_t     req,
    input  logic                      grant,
    input  app_mem_pkg::flow_entry_t  rd_entry,
    output logic                      fwd_pulse,
    output logic                      drop_pulse
);

    logic                       run;
    logic                       sof;
    logic                       in_fire;
    logic                       pend_valid;
    logic [`FLOW_KEY_BITS-1:0]  pend_key;
    logic                       look_d;

    logic                       beat_push_ready;
    logic                       beat_pop_valid;
    logic                       beat_pop_ready;
    app_pkt_pkg::axis_beat_t    beat_head;

    logic                       dec_push_ready;
    app_pkt_pkg::fwd_decision_t dec_in;
    logic                       dec_pop_valid;
    logic                       dec_pop_ready;
    app_pkt_pkg::fwd_decision_t dec_head;
    logic                       beat_fire;

    // ========================================
    // Ingress and key capture
    // ========================================

    // A first beat waits while an earlier key is still pending
    assign in_ready = run && beat_push_ready && !(sof && pend_valid);
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            run        <= 1'b0;
            sof        <= 1'b1;
            pend_valid <= 1'b0;
            look_d     <= 1'b0;
        end else begin
            run    <= 1'b1;
            look_d <= grant;
            if (in_fire) begin
                sof <= in_beat.tlast;
            end
            if (in_fire && sof) begin
                pend_valid <= 1'b1;
            end else if (grant) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axil_if) begin
        if (in_fire && sof) begin
            pend_key <= in_beat.tdata[`FLOW_KEY_BITS-1:0];
        end
    end

    // Ask only while the decision queue has room for the result
    assign req_valid = pend_valid && dec_push_ready;

    always_comb begin
        req.wr       = 1'b0;
        req.idx      = pend_key;
        req.wr_entry = '0;
        dec_in.egress = rd_entry.egress;
        dec_in.drop   = rd_entry.drop;
    end

    stream_fifo #(
        .payload_t (app_pkt_pkg::axis_beat_t),
        .DEPTH     (`BEAT_FIFO_DEPTH)
    ) beat_fifo (
        .axil_if    (axil_if),
        .arst_n     (arst_n),
        .push_valid (in_fire),
        .push_ready (beat_push_ready),
        .push_data  (in_beat),
        .pop_valid  (beat_pop_valid),
        .pop_ready  (beat_pop_ready),
        .pop_data   (beat_head)
    );

    stream_fifo #(
        .payload_t (app_pkt_pkg::fwd_decision_t),
        .DEPTH     (`DECISION_FIFO_DEPTH)
    ) dec_fifo (
        .axil_if    (axil_if),
        .arst_n     (arst_n),
        .push_valid (look_d),
        .push_ready (dec_push_ready),
        .push_data  (dec_in),
        .pop_valid  (dec_pop_valid),
        .pop_ready  (dec_pop_ready),
        .pop_data   (dec_head)
    );

    // ========================================
    // Egress, forward or discard
    // ========================================

    assign beat_pop_ready = dec_pop_valid && (dec_head.drop || out_ready);
    assign beat_fire      = beat_pop_valid && beat_pop_ready;
    assign dec_pop_ready  = beat_fire && beat_head.tlast;

    assign out_valid = dec_pop_valid && beat_pop_valid && !dec_head.drop;
    assign out_beat  = beat_head;
    assign out_tdest = dec_head.egress;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            fwd_pulse  <= 1'b0;
            drop_pulse <= 1'b0;
        end else begin
            fwd_pulse  <= dec_pop_ready && !dec_head.drop;
            drop_pulse <= dec_pop_ready && dec_head.drop;
        end
    end

    assert property (@(posedge axil_if) disable iff (!arst_n)
        out_valid && !out_ready
        |=> out_valid && $stable(out_beat) && $stable(out_tdest));

endmodule

// ==== hdl/flow_table_ram.sv ====
`timescale 1ns/1ps
`include "smartnic_app_params.svh"

module flow_table_ram (
    input  logic                     axil_if,
    input  logic                     arst_n,
    input  logic                     en,
    input  app_mem_pkg::mem_req_t    req,
    output app_mem_pkg::flow_entry_t rd_entry
);

    app_mem_pkg::flow_entry_t table_mem [`FLOW_TABLE_DEPTH];

    // Entries are defined only once written
    always_ff @(posedge axil_if) begin
        if (en && req.wr) begin
            table_mem[req.idx] <= req.wr_entry;
        end
    end

    // Registered read, valid the cycle after the enable
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            rd_entry <= '0;
        end else if (en && !req.wr) begin
            rd_entry <= table_mem[req.idx];
        end
    end

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  axil_if,
    input  logic                  arst_n,
    input  logic                  lookup_valid,
    input  app_mem_pkg::mem_req_t lookup_req,
    output logic                  lookup_grant,
    input  logic                  mgmt_valid,
    input  app_mem_pkg::mem_req_t mgmt_req,
    output logic                  mgmt_grant,
    output logic                  ram_en,
    output app_mem_pkg::mem_req_t ram_req
);

    // High when the lookup engine won the last granted cycle
    logic last_lookup;

    // ========================================
    // Grant and mux
    // ========================================

    assign lookup_grant = lookup_valid && (!mgmt_valid || !last_lookup);
    assign mgmt_grant   = mgmt_valid && (!lookup_valid || last_lookup);
    assign ram_en       = lookup_grant || mgmt_grant;
    assign ram_req      = lookup_grant ? lookup_req : mgmt_req;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            last_lookup <= 1'b0;
        end else if (ram_en) begin
            last_lookup <= lookup_grant;
        end
    end

    assert property (@(posedge axil_if) disable iff (!arst_n)
        !(lookup_grant && mgmt_grant));

endmodule

// ==== hdl/mgmt_regs.sv ====
`timescale 1ns/1ps
`include "smartnic_app_params.svh"

module mgmt_regs (
    input  logic                     axil_if,
    input  logic                     arst_n,
    input  logic                     mgmt_req_valid,
    output logic                     mgmt_req_ready,
    input  app_mem_pkg::mgmt_req_t   mgmt_req,
    output logic                     mgmt_rsp_valid,
    output app_mem_pkg::mgmt_rsp_t   mgmt_rsp,
    output logic                     req_valid,
    output app_mem_pkg::mem_req_t    req,
    input  logic                     grant,
    input  app_mem_pkg::flow_entry_t rd_entry,
    input  logic                     fwd_pulse,
    input  logic                     drop_pulse
);

    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_MEM,
        ST_RD
    } state_t;

    state_t                 state;
    app_mem_pkg::mgmt_req_t hold;
    logic [31:0]            fwd_cnt;
    logic [31:0]            drop_cnt;
    logic                   accept;
    logic                   is_table;
    logic [31:0]            local_data;

    // ========================================
    // Decode
    // ========================================

    assign mgmt_req_ready = (state == ST_IDLE);
    assign accept         = mgmt_req_valid && mgmt_req_ready;

    // 0x00 to 0x3C, word aligned
    assign is_table = (mgmt_req.addr[7:6] == 2'b00) && (mgmt_req.addr[1:0] == 2'b00);

    // Counters and unmapped space answer without the table
    always_comb begin
        case (mgmt_req.addr)
            8'h40:   local_data = fwd_cnt;
            8'h44:   local_data = drop_cnt;
            default: local_data = '0;
        endcase
        if (mgmt_req.wr) begin
            local_data = '0;
        end
    end

    assign req_valid = (state == ST_MEM);

    always_comb begin
        req.wr       = hold.wr;
        req.idx      = hold.addr[`FLOW_KEY_BITS+1:2];
        req.wr_entry = app_mem_pkg::flow_entry_t'(hold.wdata[2:0]);
    end

    // ========================================
    // Request FSM
    // ========================================

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            state          <= ST_INIT;
            mgmt_rsp_valid <= 1'b0;
        end else begin
            mgmt_rsp_valid <= 1'b0;
            case (state)
                ST_INIT: state <= ST_IDLE;
                ST_IDLE: begin
                    if (accept && is_table) begin
                        state <= ST_MEM;
                    end else if (accept) begin
                        mgmt_rsp_valid <= 1'b1;
                    end
                end
                ST_MEM: begin
                    if (grant && req.wr) begin
                        mgmt_rsp_valid <= 1'b1;
                        state          <= ST_IDLE;
                    end else if (grant) begin
                        state <= ST_RD;
                    end
                end
                // Table word arrives this cycle
                ST_RD: begin
                    mgmt_rsp_valid <= 1'b1;
                    state          <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge axil_if) begin
        if (accept) begin
            hold <= mgmt_req;
        end
        if (accept && !is_table) begin
            mgmt_rsp.rdata <= local_data;
        end else if (state == ST_MEM && grant) begin
            mgmt_rsp.rdata <= '0;
        end else if (state == ST_RD) begin
            mgmt_rsp.rdata <= {29'd0, rd_entry};
        end
    end

    // ========================================
    // Packet counters, saturating
    // ========================================

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            fwd_cnt  <= '0;
            drop_cnt <= '0;
        end else begin
            if (fwd_pulse && fwd_cnt != '1) begin
                fwd_cnt <= fwd_cnt + 1'b1;
            end
            if (drop_pulse && drop_cnt != '1) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/smartnic_app.sv ====
`timescale 1ns/1ps

module smartnic_app (
    input  logic                    axil_if,
    input  logic                    arst_n,
    // Ingress stream
    input  logic                    in_valid,
    output logic                    in_ready,
    input  app_pkt_pkg::axis_beat_t in_beat,
    // Egress stream
    output logic                    out_valid,
    input  logic                    out_ready,
    output app_pkt_pkg::axis_beat_t out_beat,
    output app_pkt_pkg::port_t      out_tdest,
    // Management port
    input  logic                    mgmt_req_valid,
    output logic                    mgmt_req_ready,
    input  app_mem_pkg::mgmt_req_t  mgmt_req,
    output logic                    mgmt_rsp_valid,
    output app_mem_pkg::mgmt_rsp_t  mgmt_rsp
);

    logic                     lookup_valid;
    app_mem_pkg::mem_req_t    lookup_req;
    logic                     lookup_grant;
    logic                     mgmt_valid;
    app_mem_pkg::mem_req_t    mgmt_mem_req;
    logic                     mgmt_grant;
    logic                     ram_en;
    app_mem_pkg::mem_req_t    ram_req;
    app_mem_pkg::flow_entry_t rd_entry;
    logic                     fwd_pulse;
    logic                     drop_pulse;

    flow_lookup flow_lookup_inst (
        .axil_if    (axil_if),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat),
        .out_tdest  (out_tdest),
        .req_valid  (lookup_valid),
        .req        (lookup_req),
        .grant      (lookup_grant),
        .rd_entry   (rd_entry),
        .fwd_pulse  (fwd_pulse),
        .drop_pulse (drop_pulse)
    );

    mgmt_regs mgmt_regs_inst (
        .axil_if        (axil_if),
        .arst_n         (arst_n),
        .mgmt_req_valid (mgmt_req_valid),
        .mgmt_req_ready (mgmt_req_ready),
        .mgmt_req       (mgmt_req),
        .mgmt_rsp_valid (mgmt_rsp_valid),
        .mgmt_rsp       (mgmt_rsp),
        .req_valid      (mgmt_valid),
        .req            (mgmt_mem_req),
        .grant          (mgmt_grant),
        .rd_entry       (rd_entry),
        .fwd_pulse      (fwd_pulse),
        .drop_pulse     (drop_pulse)
    );

    mem_arbiter mem_arbiter_inst (
        .axil_if      (axil_if),
        .arst_n       (arst_n),
        .lookup_valid (lookup_valid),
        .lookup_req   (lookup_req),
        .lookup_grant (lookup_grant),
        .mgmt_valid   (mgmt_valid),
        .mgmt_req     (mgmt_mem_req),
        .mgmt_grant   (mgmt_grant),
        .ram_en       (ram_en),
        .ram_req      (ram_req)
    );

    flow_table_ram flow_table_ram_inst (
        .axil_if  (axil_if),
        .arst_n   (arst_n),
        .en       (ram_en),
        .req      (ram_req),
        .rd_entry (rd_entry)
    );

endmodule

// ==== hdl/smartnic_app_params.svh ====
`ifndef SMARTNIC_APP_PARAMS_SVH
`define SMARTNIC_APP_PARAMS_SVH

// ========================================
// Stream geometry
// ========================================

// Bytes per beat, tdata is 8x this
`define APP_DATA_BYTES 8

// ========================================
// Flow table and buffering
// ========================================

`define FLOW_TABLE_DEPTH 16

// Key comes from the low bits of the first beat
`define FLOW_KEY_BITS 4

`define BEAT_FIFO_DEPTH 8
`define DECISION_FIFO_DEPTH 4

`endif

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     axil_if,
    input  logic     arst_n,
    input  logic     push_valid,
    output logic     push_ready,
    input  payload_t push_data,
    output logic     pop_valid,
    input  logic     pop_ready,
    output payload_t pop_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_fire;
    logic             pop_fire;

    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_data   = mem[rd_ptr];
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    // Wrap explicitly, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge axil_if) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Full stays full until a pop, so no write slips in
    assert property (@(posedge axil_if) disable iff (!arst_n)
        (count == CNT_W'(DEPTH)) && !pop_fire |=> (count == CNT_W'(DEPTH)));

    // Empty stays empty until a push, so nothing is read from it
    assert property (@(posedge axil_if) disable iff (!arst_n)
        !pop_valid && !push_fire |=> !pop_valid);

endmodule

// ==== sim/smartnic_app_golden.txt ====
# W addr data | R addr expected | P in_port key beats exp_port drop | C fwd drop
# All fields in hex, entry data is {drop, port[1:0]}
W 00 2
W 04 5
W 08 3
W 0C 4
W 10 1
W 40 DEADBEEF
R 00 2
R 04 5
R 08 3
R 40 0
R 48 0
R 3D 0
P 0 0 3 2 0
P 1 1 2 1 1
P 2 2 4 3 0
R 0C 4
P 3 3 1 0 1
P 0 4 5 1 0
R 10 1
P 1 0 2 2 0
C 4 2
W 04 1
R 04 1
P 2 1 3 1 0
P 3 3 2 0 1
C 5 3

// ==== sim/tb_smartnic_app.sv ====
`timescale 1ns/1ps
`include "smartnic_app_params.svh"

module tb_smartnic_app;

    // One golden line, op letter plus up to five hex fields
    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
    } golden_cmd_t;

    typedef struct packed {
        app_pkt_pkg::axis_beat_t beat;
        app_pkt_pkg::port_t      tdest;
    } exp_beat_t;

    logic                    axil_if;
    logic                    arst_n;
    logic                    in_valid;
    logic                    in_ready;
    app_pkt_pkg::axis_beat_t in_beat;
    logic                    out_valid;
    logic                    out_ready;
    app_pkt_pkg::axis_beat_t out_beat;
    app_pkt_pkg::port_t      out_tdest;
    logic                    mgmt_req_valid;
    logic                    mgmt_req_ready;
    app_mem_pkg::mgmt_req_t  mgmt_req;
    logic                    mgmt_rsp_valid;
    app_mem_pkg::mgmt_rsp_t  mgmt_rsp;

    golden_cmd_t             cmds[$];
    app_pkt_pkg::axis_beat_t send_q[$];
    exp_beat_t               exp_q[$];
    exp_beat_t               mon_beat;
    logic [31:0]             pay_state;
    logic [31:0]             rdy_state;
    int                      errors;
    int                      req_count;
    int                      rsp_count;
    logic                    loaded;
    logic                    rst_done;

    smartnic_app smartnic_app_inst (
        .axil_if        (axil_if),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_beat        (in_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_beat       (out_beat),
        .out_tdest      (out_tdest),
        .mgmt_req_valid (mgmt_req_valid),
        .mgmt_req_ready (mgmt_req_ready),
        .mgmt_req       (mgmt_req),
        .mgmt_rsp_valid (mgmt_rsp_valid),
        .mgmt_rsp       (mgmt_rsp)
    );

    // ========================================
    // Helpers
    // ========================================

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = st[0];
            st   = lfsr_next(st);
        end
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, act);
        end
    endtask

    task automatic check_quiet();
        compare("out_valid", 64'd0, out_valid);
        compare("mgmt_req_ready", 64'd0, mgmt_req_ready);
        compare("mgmt_rsp_valid", 64'd0, mgmt_rsp_valid);
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        golden_cmd_t c;
        byte         op;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] v5;
        fd = $fopen("sim/smartnic_app_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the golden file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                v1 = '0;
                v2 = '0;
                v3 = '0;
                v4 = '0;
                v5 = '0;
                n  = $sscanf(line, "%c %h %h %h %h %h", op, v1, v2, v3, v4, v5);
                c  = {op, v1, v2, v3, v4, v5};
                cmds.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic mgmt_access(input logic wr, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge axil_if);
        #1;
        mgmt_req_valid = 1'b1;
        mgmt_req.wr    = wr;
        mgmt_req.addr  = addr;
        mgmt_req.wdata = wdata;
        @(negedge axil_if);
        while (!mgmt_req_ready) begin
            @(negedge axil_if);
        end
        @(posedge axil_if);
        #1;
        mgmt_req_valid = 1'b0;
        req_count++;
        waited = 0;
        @(negedge axil_if);
        while (!mgmt_rsp_valid && waited < 20) begin
            waited++;
            @(negedge axil_if);
        end
        if (!mgmt_rsp_valid) begin
            errors++;
            $display("No management response for address 0x%0h", addr);
        end
        rdata = mgmt_rsp.rdata;
    endtask

    // Builds the beats, forwarded packets also go to the expected queue
    task automatic queue_packet(input golden_cmd_t c);
        app_pkt_pkg::axis_beat_t b;
        exp_beat_t               e;
        logic [63:0]             r;
        for (int i = 0; i < c.f3; i++) begin
            draw_bits(pay_state, 64, r);
            b.tdata = r;
            if (i == 0) begin
                b.tdata[`FLOW_KEY_BITS-1:0] = c.f2[`FLOW_KEY_BITS-1:0];
            end
            b.tlast = (i == c.f3 - 1);
            b.tkeep = {`APP_DATA_BYTES{1'b1}};
            if (b.tlast) begin
                draw_bits(pay_state, 3, r);
                b.tkeep = {`APP_DATA_BYTES{1'b1}} >> r[2:0];
            end
            b.tid = c.f1[1:0];
            send_q.push_back(b);
            if (!c.f5[0]) begin
                e.beat  = b;
                e.tdest = c.f4[1:0];
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic wait_drain();
        while (send_q.size() != 0 || exp_q.size() != 0) begin
            @(posedge axil_if);
        end
    endtask

    // Counters lag the last beat, so poll until they settle
    task automatic check_counters(input golden_cmd_t c);
        logic [31:0] fwd;
        logic [31:0] drop;
        int          tries;
        wait_drain();
        tries = 0;
        mgmt_access(1'b0, 8'h40, 32'd0, fwd);
        mgmt_access(1'b0, 8'h44, 32'd0, drop);
        while ((fwd !== c.f1 || drop !== c.f2) && tries < 50) begin
            tries++;
            mgmt_access(1'b0, 8'h40, 32'd0, fwd);
            mgmt_access(1'b0, 8'h44, 32'd0, drop);
        end
        compare("fwd_count", c.f1, fwd);
        compare("drop_count", c.f2, drop);
    endtask

    // ========================================
    // Clock, watchdog and stream drivers
    // ========================================

    initial begin
        axil_if = 1'b0;
        forever begin
            #4 axil_if = ~axil_if;
        end
    end

    initial begin
        wait (loaded);
        repeat (cmds.size() * 200 + 1000) @(posedge axil_if);
        $display("Timeout, the run did not finish within the cycle budget");
        $display("Some tests failed");
        $finish;
    end

    initial begin : ingress_driver
        logic sent;
        sent = 1'b0;
        wait (rst_done);
        forever begin
            @(posedge axil_if);
            #1;
            if (sent) begin
                void'(send_q.pop_front());
            end
            in_valid = (send_q.size() != 0);
            if (in_valid) begin
                in_beat = send_q[0];
            end
            @(negedge axil_if);
            sent = in_valid && in_ready;
        end
    end

    // Roughly one cycle in four with out_ready low
    initial begin : ready_driver
        logic [63:0] r;
        wait (rst_done);
        forever begin
            @(posedge axil_if);
            #1;
            draw_bits(rdy_state, 2, r);
            out_ready = (r[1:0] != 2'b00);
        end
    end

    always @(negedge axil_if) begin
        if (arst_n && mgmt_rsp_valid) begin
            rsp_count++;
        end
        if (arst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output beat appeared while no forwarded beat was expected");
            end else begin
                mon_beat = exp_q.pop_front();
                compare("out_beat.tdata", mon_beat.beat.tdata, out_beat.tdata);
                compare("out_beat.tkeep", mon_beat.beat.tkeep, out_beat.tkeep);
                compare("out_beat.tlast", mon_beat.beat.tlast, out_beat.tlast);
                compare("out_beat.tid", mon_beat.beat.tid, out_beat.tid);
                compare("out_tdest", mon_beat.tdest, out_tdest);
            end
        end
    end

    // ========================================
    // Main sequence
    // ========================================

    initial begin : main_flow
        logic [31:0] rdata;
        golden_cmd_t c;
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_beat        = '0;
        out_ready      = 1'b0;
        mgmt_req_valid = 1'b0;
        mgmt_req       = '0;
        errors         = 0;
        req_count      = 0;
        rsp_count      = 0;
        rst_done       = 1'b0;
        loaded         = 1'b0;
        pay_state      = 32'h7a18702b;
        rdy_state      = 32'h7a18702b;
        load_golden();
        loaded = 1'b1;
        #1;
        check_quiet();
        for (int i = 0; i < 3; i++) begin
            @(posedge axil_if);
            #1;
            if (i == 2) begin
                arst_n = 1'b1;
            end
            @(negedge axil_if);
            check_quiet();
        end
        rst_done = 1'b1;
        for (int k = 0; k < cmds.size(); k++) begin
            c = cmds[k];
            case (c.op)
                "W": mgmt_access(1'b1, c.f1[7:0], c.f2, rdata);
                "R": begin
                    mgmt_access(1'b0, c.f1[7:0], 32'd0, rdata);
                    compare("mgmt_rsp.rdata", c.f2, rdata);
                end
                "P": queue_packet(c);
                "C": check_counters(c);
                default: begin
                    errors++;
                    $display("Unknown command in golden line %0d", k);
                end
            endcase
        end
        wait_drain();
        @(posedge axil_if);
        compare("mgmt_rsp_count", req_count, rsp_count);
        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== smartnic_app.f ====
+incdir+hdl
hdl/app_pkt_pkg.sv
hdl/app_mem_pkg.sv
hdl/stream_fifo.sv
hdl/flow_table_ram.sv
hdl/mem_arbiter.sv
hdl/flow_lookup.sv
hdl/mgmt_regs.sv
hdl/smartnic_app.sv
sim/tb_smartnic_app.sv
